/* rtl/autotest_pkg.sv */
//********************
// shared block layout, limits and types for the SD autotest controller
//********************
package autotest_pkg;

  // SD block geometry
  localparam int unsigned BYTE_W      = 8;
  localparam int unsigned BLOCK_BYTES = 512;
  localparam int unsigned BYTE_IDX_W  = 9;

  localparam logic [31:0] SIGNATURE   = 32'hAABBCCDD;
  localparam logic [31:0] START_BLOCK = 32'h00100000;

  // field offsets inside a test block
  // signature is msb first, all other fields lsb first
  localparam int unsigned OFS_SIG     = 0;
  localparam int unsigned OFS_IN1     = 4;
  localparam int unsigned OFS_IN2     = 8;
  localparam int unsigned OFS_EXP     = 12;
  localparam int unsigned OFS_OUT     = 16;
  localparam int unsigned OFS_TIME    = 20;
  localparam int unsigned FIELD_BYTES = 4;

  // run length after which the UUT counts as hung
  localparam int unsigned TIMEOUT_CYCLES = 300;

  typedef logic [BYTE_W-1:0]     byte_t;
  typedef logic [BYTE_IDX_W-1:0] byte_idx_t;
  typedef logic [31:0]           block_addr_t;
  typedef logic [31:0]           operand_t;
  typedef logic [31:0]           result_t;
  typedef logic [31:0]           cycles_t;

  typedef enum logic [1:0] {
    OP_RESET,
    OP_READ,
    OP_WRITE
  } sd_op_e;

  typedef enum logic [3:0] {
    S_INIT,
    S_SD_RESET,
    S_IDLE,
    S_READ,
    S_CHECK,
    S_RUN,
    S_WRITE,
    S_NEXT,
    S_HALT
  } seq_state_e;

endpackage

/* rtl/sd_xfer_if.sv */
//********************
// block operation requests and byte traffic between sequencer, engine, buffer
//********************
`timescale 1ns/10ps

interface sd_xfer_if;
  import autotest_pkg::*;

  logic      op_start;
  sd_op_e    op;
  logic      op_done;
  byte_idx_t byte_idx;
  logic      rd_valid;
  byte_t     rd_byte;
  // combinational on byte_idx
  byte_t     wr_byte;

  modport seq (output op_start, output op, input op_done);

  modport engine (input op_start, input op, input wr_byte,
                  output op_done, output byte_idx, output rd_valid, output rd_byte);

  modport buffer (input byte_idx, input rd_valid, input rd_byte, output wr_byte);

endinterface

/* rtl/sd_block_engine.sv */
//********************
// busy-line handshake with the SPI SD host for block reset, read and write
//********************
`timescale 1ns/10ps

module sd_block_engine (
  input  logic                 clk,
  input  logic                 rst,
  sd_xfer_if.engine            xfer,
  input  logic                 spi_busy_i,
  input  autotest_pkg::byte_t  spi_data_out_i,
  output logic                 spi_rst_o,
  output logic                 spi_r_block_o,
  output logic                 spi_r_byte_o,
  output logic                 spi_w_block_o,
  output logic                 spi_w_byte_o,
  output autotest_pkg::byte_t  spi_data_in_o
);
  import autotest_pkg::*;

  typedef enum logic [2:0] {E_IDLE, E_OPEN, E_LOAD, E_REQ, E_WAIT} eng_state_e;

  eng_state_e state;
  sd_op_e     op_q;
  logic       busy_seen;
  logic       in_block;
  logic       byte_done;
  logic       last_byte;

  assign in_block  = (state != E_IDLE);
  assign byte_done = (state == E_WAIT) && !spi_busy_i;
  assign last_byte = (xfer.byte_idx == byte_idx_t'(BLOCK_BYTES - 1));

  assign spi_rst_o     = (state == E_OPEN) && (op_q == OP_RESET) && !busy_seen;
  assign spi_r_block_o = in_block && (op_q == OP_READ);
  assign spi_w_block_o = in_block && (op_q == OP_WRITE);
  assign spi_r_byte_o  = (state == E_REQ) && (op_q == OP_READ);
  assign spi_w_byte_o  = (state == E_REQ) && (op_q == OP_WRITE);

  // read byte is taken at the falling edge of busy
  assign xfer.rd_valid = byte_done && (op_q == OP_READ);
  assign xfer.rd_byte  = spi_data_out_i;
  assign xfer.op_done  = (byte_done && last_byte) ||
                         ((state == E_OPEN) && (op_q == OP_RESET) && busy_seen && !spi_busy_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= E_IDLE;
      op_q          <= OP_RESET;
      busy_seen     <= 1'b0;
      xfer.byte_idx <= '0;
    end else begin
      case (state)
        E_IDLE: begin
          if (xfer.op_start) begin
            op_q          <= xfer.op;
            busy_seen     <= 1'b0;
            xfer.byte_idx <= '0;
            state         <= E_OPEN;
          end
        end
        E_OPEN: begin
          if (!busy_seen) begin
            busy_seen <= spi_busy_i;
          end else if (!spi_busy_i) begin
            state <= (op_q == OP_RESET) ? E_IDLE : E_LOAD;
          end
        end
        E_LOAD: state <= E_REQ;
        E_REQ: begin
          if (spi_busy_i) state <= E_WAIT;
        end
        E_WAIT: begin
          if (!spi_busy_i) begin
            if (last_byte) begin
              state <= E_IDLE;
            end else begin
              xfer.byte_idx <= xfer.byte_idx + 1'b1;
              state         <= E_LOAD;
            end
          end
        end
        default: state <= E_IDLE;
      endcase
    end
  end

  // write data settles one cycle before the byte request
  always_ff @(posedge clk) begin
    if (state == E_LOAD) spi_data_in_o <= xfer.wr_byte;
  end

endmodule

/* rtl/block_buffer.sv */
//********************
// block store with field decode on read and patched bytes on write-back
//********************
`timescale 1ns/10ps

module block_buffer (
  input  logic                    clk,
  input  logic                    rst,
  sd_xfer_if.buffer               xfer,
  output autotest_pkg::operand_t  in1_o,
  output autotest_pkg::operand_t  in2_o,
  output autotest_pkg::result_t   expected_o,
  output logic                    sig_ok_o,
  input  autotest_pkg::result_t   result_i,
  input  autotest_pkg::cycles_t   exec_cycles_i
);
  import autotest_pkg::*;

  byte_t       mem [BLOCK_BYTES];
  logic [31:0] sig_q;

  function automatic logic in_field(byte_idx_t idx, int unsigned ofs);
    return (idx >= ofs) && (idx < ofs + FIELD_BYTES);
  endfunction

  function automatic logic [1:0] lane(byte_idx_t idx, int unsigned ofs);
    return 2'(idx - ofs);
  endfunction

  assign sig_ok_o = (sig_q == SIGNATURE);

  // signature arrives msb first
  always_ff @(posedge clk) begin
    if (rst) begin
      sig_q <= '0;
    end else if (xfer.rd_valid && in_field(xfer.byte_idx, OFS_SIG)) begin
      sig_q[(FIELD_BYTES - 1 - lane(xfer.byte_idx, OFS_SIG)) * BYTE_W +: BYTE_W] <= xfer.rd_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer.rd_valid) begin
      mem[xfer.byte_idx] <= xfer.rd_byte;
      if (in_field(xfer.byte_idx, OFS_IN1)) begin
        in1_o[lane(xfer.byte_idx, OFS_IN1) * BYTE_W +: BYTE_W] <= xfer.rd_byte;
      end
      if (in_field(xfer.byte_idx, OFS_IN2)) begin
        in2_o[lane(xfer.byte_idx, OFS_IN2) * BYTE_W +: BYTE_W] <= xfer.rd_byte;
      end
      if (in_field(xfer.byte_idx, OFS_EXP)) begin
        expected_o[lane(xfer.byte_idx, OFS_EXP) * BYTE_W +: BYTE_W] <= xfer.rd_byte;
      end
    end
  end

  // write-back source, result and time patched in lsb first
  always_comb begin
    if (in_field(xfer.byte_idx, OFS_OUT)) begin
      xfer.wr_byte = result_i[lane(xfer.byte_idx, OFS_OUT) * BYTE_W +: BYTE_W];
    end else if (in_field(xfer.byte_idx, OFS_TIME)) begin
      xfer.wr_byte = exec_cycles_i[lane(xfer.byte_idx, OFS_TIME) * BYTE_W +: BYTE_W];
    end else begin
      xfer.wr_byte = mem[xfer.byte_idx];
    end
  end

endmodule

/* rtl/uut_runner.sv */
//********************
// releases the UUT, times its run with timeout and checks the result
//********************
`timescale 1ns/10ps

module uut_runner (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   run_start_i,
  output logic                   run_done_o,
  output logic                   uut_rst_o,
  input  logic                   uut_end_i,
  input  autotest_pkg::result_t  result_i,
  input  autotest_pkg::result_t  expected_i,
  output autotest_pkg::result_t  result_o,
  output autotest_pkg::cycles_t  exec_cycles_o,
  output autotest_pkg::cycles_t  error_count_o
);
  import autotest_pkg::*;

  logic cmp_pending;
  logic run_end;

  // ends on uut_end_i or when this edge would reach the cap
  assign run_end    = !uut_rst_o && (uut_end_i || exec_cycles_o == cycles_t'(TIMEOUT_CYCLES));
  assign run_done_o = cmp_pending;

  always_ff @(posedge clk) begin
    if (rst) begin
      uut_rst_o     <= 1'b1;
      cmp_pending   <= 1'b0;
      error_count_o <= '0;
    end else begin
      cmp_pending <= run_end;
      if (run_start_i) begin
        uut_rst_o <= 1'b0;
      end else if (run_end) begin
        uut_rst_o <= 1'b1;
      end
      if (cmp_pending && (result_o != expected_i)) begin
        error_count_o <= error_count_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run_start_i) begin
      exec_cycles_o <= '0;
    end else if (!uut_rst_o) begin
      if (!uut_end_i) exec_cycles_o <= exec_cycles_o + 1'b1;
      if (run_end) result_o <= result_i;
    end
  end

endmodule

/* rtl/test_sequencer.sv */
//********************
// main loop: SD reset, then read, check, run, write back and next block
//********************
`timescale 1ns/10ps

module test_sequencer (
  input  logic                       clk,
  input  logic                       rst,
  sd_xfer_if.seq                     xfer,
  input  logic                       sig_ok_i,
  output logic                       run_start_o,
  input  logic                       run_done_i,
  output autotest_pkg::block_addr_t  block_addr_o,
  output logic                       halted_o
);
  import autotest_pkg::*;

  seq_state_e state;
  seq_state_e next_state;

  assign halted_o = (state == S_HALT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_INIT;
      block_addr_o <= START_BLOCK;
    end else begin
      state <= next_state;
      if (state == S_NEXT) block_addr_o <= block_addr_o + 1'b1;
    end
  end

  // requests go out only while the engine is idle
  always_comb begin
    next_state    = state;
    xfer.op_start = 1'b0;
    xfer.op       = OP_READ;
    run_start_o   = 1'b0;

    case (state)
      S_INIT: begin
        xfer.op_start = 1'b1;
        xfer.op       = OP_RESET;
        next_state    = S_SD_RESET;
      end
      S_SD_RESET: begin
        if (xfer.op_done) next_state = S_IDLE;
      end
      S_IDLE: begin
        xfer.op_start = 1'b1;
        xfer.op       = OP_READ;
        next_state    = S_READ;
      end
      S_READ: begin
        if (xfer.op_done) next_state = S_CHECK;
      end
      S_CHECK: begin
        if (sig_ok_i) begin
          run_start_o = 1'b1;
          next_state  = S_RUN;
        end else begin
          next_state = S_HALT;
        end
      end
      S_RUN: begin
        // write-back starts once the result has been compared
        if (run_done_i) begin
          xfer.op_start = 1'b1;
          xfer.op       = OP_WRITE;
          next_state    = S_WRITE;
        end
      end
      S_WRITE: begin
        if (xfer.op_done) next_state = S_NEXT;
      end
      S_NEXT: next_state = S_IDLE;
      S_HALT: next_state = S_HALT;
      default: next_state = S_HALT;
    endcase
  end

endmodule

/* rtl/sd_autotest_top.sv */
//********************
// SD card driven autotest controller, connects to an SPI SD host and the UUT
//********************
`timescale 1ns/10ps

module sd_autotest_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       spi_busy_i,
  input  autotest_pkg::byte_t        spi_data_out_i,
  output logic                       spi_rst_o,
  output logic                       spi_r_block_o,
  output logic                       spi_r_byte_o,
  output logic                       spi_w_block_o,
  output logic                       spi_w_byte_o,
  output autotest_pkg::byte_t        spi_data_in_o,
  output autotest_pkg::block_addr_t  spi_block_addr_o,
  output logic                       uut_rst_o,
  input  logic                       uut_end_i,
  output autotest_pkg::operand_t     uut_in1_o,
  output autotest_pkg::operand_t     uut_in2_o,
  input  autotest_pkg::result_t      uut_result_i,
  output autotest_pkg::cycles_t      error_count_o,
  output logic                       halted_o
);
  import autotest_pkg::*;

  logic    sig_ok;
  logic    run_start;
  logic    run_done;
  result_t expected;
  result_t result_q;
  cycles_t exec_cycles;

  sd_xfer_if xfer ();

  test_sequencer u_seq (
    .clk(clk), .rst(rst), .xfer(xfer.seq), .sig_ok_i(sig_ok),
    .run_start_o(run_start), .run_done_i(run_done),
    .block_addr_o(spi_block_addr_o), .halted_o(halted_o)
  );

  sd_block_engine u_engine (
    .clk(clk), .rst(rst), .xfer(xfer.engine),
    .spi_busy_i(spi_busy_i), .spi_data_out_i(spi_data_out_i), .spi_rst_o(spi_rst_o),
    .spi_r_block_o(spi_r_block_o), .spi_r_byte_o(spi_r_byte_o),
    .spi_w_block_o(spi_w_block_o), .spi_w_byte_o(spi_w_byte_o),
    .spi_data_in_o(spi_data_in_o)
  );

  block_buffer u_buffer (
    .clk(clk), .rst(rst), .xfer(xfer.buffer), .in1_o(uut_in1_o), .in2_o(uut_in2_o),
    .expected_o(expected), .sig_ok_o(sig_ok), .result_i(result_q),
    .exec_cycles_i(exec_cycles)
  );

  uut_runner u_runner (
    .clk(clk), .rst(rst), .run_start_i(run_start), .run_done_o(run_done),
    .uut_rst_o(uut_rst_o), .uut_end_i(uut_end_i), .result_i(uut_result_i),
    .expected_i(expected), .result_o(result_q), .exec_cycles_o(exec_cycles),
    .error_count_o(error_count_o)
  );

endmodule

/* bench/sd_autotest_sva.sv */
//********************
// assertions on the SD strobes and UUT reset, bound to the top level
//********************
`timescale 1ns/10ps

module sd_autotest_sva (
  input logic clk,
  input logic rst,
  input logic spi_rst_o,
  input logic spi_r_block_o,
  input logic spi_r_byte_o,
  input logic spi_w_block_o,
  input logic spi_w_byte_o,
  input logic uut_rst_o
);

  a_one_block: assert property (@(posedge clk) disable iff (rst)
    !(spi_r_block_o && spi_w_block_o))
    else $error("read and write block strobes high together");

  a_byte_in_block: assert property (@(posedge clk) disable iff (rst)
    spi_r_byte_o |-> spi_r_block_o)
    else $error("read byte request outside a read block");

  // UUT stays in reset during SD traffic
  a_uut_held: assert property (@(posedge clk) disable iff (rst)
    (spi_rst_o || spi_r_block_o || spi_r_byte_o || spi_w_block_o || spi_w_byte_o)
      |-> uut_rst_o)
    else $error("SD strobe high while UUT released");

endmodule

bind sd_autotest_top sd_autotest_sva u_sva (
  .clk(clk), .rst(rst), .spi_rst_o(spi_rst_o), .spi_r_block_o(spi_r_block_o),
  .spi_r_byte_o(spi_r_byte_o), .spi_w_block_o(spi_w_block_o),
  .spi_w_byte_o(spi_w_byte_o), .uut_rst_o(uut_rst_o)
);

/* bench/tb_sd_autotest.sv */
//********************
// testbench for the SD autotest controller with SD host and UUT models
// random block images, scoreboard checks on every write-back
//********************
`timescale 1ns/10ps

module tb_sd_autotest;
  import autotest_pkg::*;

  localparam int NUM_BLOCKS = 13;
  localparam int WATCHDOG_CYCLES = 14 * 2 * 512 * 12 + 14 * 400;

  logic        clk;
  logic        rst;
  logic        spi_busy_i;
  byte_t       spi_data_out_i;
  logic        spi_rst_o;
  logic        spi_r_block_o;
  logic        spi_r_byte_o;
  logic        spi_w_block_o;
  logic        spi_w_byte_o;
  byte_t       spi_data_in_o;
  block_addr_t spi_block_addr_o;
  logic        uut_rst_o;
  logic        uut_end_i;
  operand_t    uut_in1_o;
  operand_t    uut_in2_o;
  result_t     uut_result_i;
  cycles_t     error_count_o;
  logic        halted_o;

  byte_t       img [longint];
  byte_t       wr_buf [BLOCK_BYTES];
  int          run_len [NUM_BLOCKS];
  bit          hangs [NUM_BLOCKS];
  logic [31:0] rng;
  int          mismatches;
  int          failures;
  int          reads;
  int          writes;
  int          exp_errors;
  bit          first_cmd;
  block_addr_t last_read;

  sd_autotest_top u_dut (.*);

  // UUT model adds its operands
  assign uut_result_i = uut_in1_o + uut_in2_o;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic longint key(block_addr_t a, int i);
    return longint'(a) * BLOCK_BYTES + i;
  endfunction

  // lsb first field from a stored image
  function automatic logic [31:0] field(block_addr_t a, int ofs);
    logic [31:0] v;
    for (int k = 0; k < FIELD_BYTES; k++) v[k*8 +: 8] = img[key(a, ofs + k)];
    return v;
  endfunction

  task automatic check_byte(byte_t got, byte_t exp, string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_result(result_t got, result_t exp, string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_cycles(cycles_t got, cycles_t exp, string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(block_addr_t got, block_addr_t exp, string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic put_field(block_addr_t a, int ofs, logic [31:0] v);
    for (int k = 0; k < FIELD_BYTES; k++) img[key(a, ofs + k)] = v[k*8 +: 8];
  endtask

  task automatic build_images();
    block_addr_t a;
    logic [31:0] sig;
    logic [31:0] sum;
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      a = START_BLOCK + b;
      for (int i = 0; i < BLOCK_BYTES; i++) img[key(a, i)] = byte_t'(next_rand());
      // last block gets a corrupted signature
      sig = (b < NUM_BLOCKS - 1) ? SIGNATURE : SIGNATURE ^ 32'h1;
      for (int k = 0; k < FIELD_BYTES; k++) img[key(a, OFS_SIG + k)] = sig[(3-k)*8 +: 8];
      sum = field(a, OFS_IN1) + field(a, OFS_IN2);
      put_field(a, OFS_EXP, (b % 3 == 1) ? sum + 32'd1 : sum);
      run_len[b] = 1 + int'(next_rand() % 80);
      hangs[b] = (b == 4) || (b == 9);
    end
  endtask

  task automatic busy_pulse();
    int n;
    n = 1 + int'(next_rand() % 4);
    spi_busy_i = 1'b1;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
    spi_busy_i = 1'b0;
  endtask

  task automatic read_block();
    block_addr_t a;
    a = spi_block_addr_o;
    check_addr(a, START_BLOCK + reads, "read address");
    busy_pulse();
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      while (!spi_r_byte_o) begin
        @(posedge clk);
        #1;
      end
      spi_data_out_i = img[key(a, i)];
      busy_pulse();
    end
    last_read = a;
    reads++;
  endtask

  task automatic check_written(block_addr_t a);
    int b;
    logic [31:0] sum;
    logic [31:0] got_res;
    logic [31:0] got_time;
    b = int'(a - START_BLOCK);
    if (b < 0 || b >= NUM_BLOCKS - 1) begin
      failures++;
      $display("write-back to block %08h, which holds no valid test", a);
      return;
    end
    sum = field(a, OFS_IN1) + field(a, OFS_IN2);
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      if (i >= OFS_OUT && i < OFS_TIME + FIELD_BYTES) continue;
      check_byte(wr_buf[i], img[key(a, i)], "copied byte");
    end
    for (int k = 0; k < FIELD_BYTES; k++) begin
      got_res[k*8 +: 8]  = wr_buf[OFS_OUT + k];
      got_time[k*8 +: 8] = wr_buf[OFS_TIME + k];
    end
    check_result(got_res, sum, "result field");
    check_cycles(got_time, hangs[b] ? TIMEOUT_CYCLES + 1 : run_len[b], "time field");
    if (sum != field(a, OFS_EXP)) exp_errors++;
    check_cycles(error_count_o, exp_errors, "error count");
  endtask

  task automatic write_block();
    block_addr_t a;
    a = spi_block_addr_o;
    check_addr(a, last_read, "write address");
    busy_pulse();
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      while (!spi_w_byte_o) begin
        @(posedge clk);
        #1;
      end
      wr_buf[i] = spi_data_in_o;
      busy_pulse();
    end
    writes++;
    check_written(a);
  endtask

  // SD host model
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (!rst) begin
        if (first_cmd && (spi_rst_o || spi_r_block_o || spi_w_block_o)) begin
          if (!spi_rst_o) begin
            failures++;
            $display("first SD command after reset was not an SD reset");
          end
          first_cmd = 1'b0;
        end
        if (spi_rst_o) busy_pulse();
        else if (spi_r_block_o) read_block();
        else if (spi_w_block_o) write_block();
      end
    end
  end

  // UUT model counts released cycles before end
  initial begin
    int  cnt;
    int  cur;
    bit  rst_prev;
    bit  end_prev;
    cnt = 0;
    rst_prev = 1'b1;
    end_prev = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (!rst_prev && !end_prev) cnt++;
      cur = int'(last_read - START_BLOCK);
      // operands seen by the UUT at release
      if (rst_prev && !uut_rst_o) begin
        check_result(uut_in1_o, field(last_read, OFS_IN1), "operand 1");
        check_result(uut_in2_o, field(last_read, OFS_IN2), "operand 2");
      end
      if (uut_rst_o) begin
        cnt = 0;
        uut_end_i = 1'b0;
      end else if (cur >= 0 && cur < NUM_BLOCKS && !hangs[cur] && cnt >= run_len[cur]) begin
        uut_end_i = 1'b1;
      end
      rst_prev = uut_rst_o;
      end_prev = uut_end_i;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before the controller halted");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int r;
    int w;
    rst = 1'b1;
    spi_busy_i = 1'b0;
    spi_data_out_i = '0;
    uut_end_i = 1'b0;
    rng = 32'd86;
    first_cmd = 1'b1;
    last_read = START_BLOCK;
    build_images();
    repeat (16) @(posedge clk);
    #1;
    check_byte(byte_t'({spi_r_block_o, spi_r_byte_o, spi_w_block_o, spi_w_byte_o}), 8'h0,
               "strobes after reset");
    check_byte(byte_t'({uut_rst_o, halted_o}), 8'h2, "uut reset and halt after reset");
    check_cycles(error_count_o, 0, "error count after reset");
    check_addr(spi_block_addr_o, START_BLOCK, "block address after reset");
    rst = 1'b0;
    while (!halted_o) begin
      @(posedge clk);
      #1;
    end
    check_cycles(reads, NUM_BLOCKS, "reads at halt");
    check_cycles(writes, NUM_BLOCKS - 1, "writes at halt");
    r = reads;
    w = writes;
    repeat (400) @(posedge clk);
    #1;
    if (reads != r || writes != w || spi_r_block_o || spi_w_block_o) begin
      failures++;
      $display("SD traffic continued after the controller halted");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
rtl/autotest_pkg.sv
rtl/sd_xfer_if.sv
rtl/sd_block_engine.sv
rtl/block_buffer.sv
rtl/uut_runner.sv
rtl/test_sequencer.sv
rtl/sd_autotest_top.sv
bench/sd_autotest_sva.sv
bench/tb_sd_autotest.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sd_autotest
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
